// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define INST_WIDTH 16

// Register file geometry
`define NUM_REGS 16
`define REG_ADDR_WIDTH 4

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/core_pkg.sv
`include "core_config.svh"

package core_pkg;

  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`INST_WIDTH-1:0] inst_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Top nibble of the instruction
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_MOVI = 4'd1,
    OP_ADD  = 4'd2,
    OP_SUB  = 4'd3,
    OP_AND  = 4'd4,
    OP_OR   = 4'd5,
    OP_XOR  = 4'd6,
    OP_ADDI = 4'd7,
    OP_LDR  = 4'd8,
    OP_STR  = 4'd9
  } op_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    logic      use_lit;
    reg_addr_t rd;
    reg_addr_t rn;
    logic [7:0] literal;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } dec_ctrl_t;

  // Result doubles as the data bus address for LDR and STR
  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t rd;
    data_t     result;
    data_t     store_data;
  } exec_res_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    data_t     data;
  } wb_t;

endpackage

// File: hdl/core_ifetch.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_ifetch
  import core_pkg::*;
(
  input  logic  core_clk,
  input  logic  rst_n_i,
  input  logic  stall_i,
  output addr_t inst_addr_o,
  output logic  inst_valid_o,
  input  inst_t inst_data_i,
  input  logic  inst_valid_i,
  output inst_t fetch_inst_o,
  output logic  fetch_valid_o
);

  addr_t pc_q;
  logic  req_q;
  logic  buf_valid_q;
  inst_t buf_inst_q;
  logic  drain;
  logic  fill;

  // Decode takes the buffer whenever the pipe is not stalled
  assign drain = buf_valid_q && !stall_i;
  // Once raised, the request stays up until the bus answers
  assign inst_valid_o = req_q || !buf_valid_q || drain;
  assign inst_addr_o = pc_q;
  assign fill = inst_valid_o && inst_valid_i;

  assign fetch_inst_o = buf_inst_q;
  assign fetch_valid_o = buf_valid_q;

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pc_q <= `RESET_PC;
      req_q <= 1'b0;
      buf_valid_q <= 1'b0;
    end
    else
    begin
      req_q <= inst_valid_o && !inst_valid_i;
      if (fill)
      begin
        pc_q <= pc_q + addr_t'(2);
        buf_valid_q <= 1'b1;
      end
      else if (drain)
        buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (fill)
      buf_inst_q <= inst_data_i;
  end

endmodule

// File: hdl/core_decode.sv
`timescale 1ns/1ps

module core_decode
  import core_pkg::*;
(
  input  logic      core_clk,
  input  logic      rst_n_i,
  input  logic      stall_i,
  input  inst_t     fetch_inst_i,
  input  logic      fetch_valid_i,
  output dec_ctrl_t dec_o
);

  dec_ctrl_t dec_d;
  dec_ctrl_t dec_q;
  op_e       op;

  assign op = op_e'(fetch_inst_i[15:12]);

  always_comb
  begin
    dec_d = '0;
    dec_d.valid = fetch_valid_i;
    dec_d.rd = fetch_inst_i[11:8];
    dec_d.rn = fetch_inst_i[7:4];
    dec_d.literal = fetch_inst_i[7:0];
    dec_d.alu_op = ALU_ADD;
    case (op)
      OP_MOVI:
      begin
        dec_d.alu_op = ALU_PASS_B;
        dec_d.use_lit = 1'b1;
        dec_d.reg_write = 1'b1;
      end
      OP_ADD:
      begin
        dec_d.reg_write = 1'b1;
      end
      OP_SUB:
      begin
        dec_d.alu_op = ALU_SUB;
        dec_d.reg_write = 1'b1;
      end
      OP_AND:
      begin
        dec_d.alu_op = ALU_AND;
        dec_d.reg_write = 1'b1;
      end
      OP_OR:
      begin
        dec_d.alu_op = ALU_OR;
        dec_d.reg_write = 1'b1;
      end
      OP_XOR:
      begin
        dec_d.alu_op = ALU_XOR;
        dec_d.reg_write = 1'b1;
      end
      OP_ADDI:
      begin
        dec_d.use_lit = 1'b1;
        dec_d.reg_write = 1'b1;
      end
      // Address is rn passed straight through the ALU
      OP_LDR:
      begin
        dec_d.alu_op = ALU_PASS_B;
        dec_d.mem_read = 1'b1;
        dec_d.reg_write = 1'b1;
      end
      OP_STR:
      begin
        dec_d.alu_op = ALU_PASS_B;
        dec_d.mem_write = 1'b1;
      end
      default:
      begin
        dec_d.reg_write = 1'b0;
      end
    endcase
    // Empty buffer becomes a bubble
    if (!fetch_valid_i)
      dec_d = '0;
  end

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dec_q <= '0;
    else if (!stall_i)
      dec_q <= dec_d;
  end

  assign dec_o = dec_q;

endmodule

// File: hdl/core_regfile.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_regfile
  import core_pkg::*;
(
  input  logic      core_clk,
  input  logic      rst_n_i,
  input  reg_addr_t rd_addr_i,
  input  reg_addr_t rn_addr_i,
  output data_t     rd_data_o,
  output data_t     rn_data_o,
  input  wb_t       wb_i
);

  data_t regs [`NUM_REGS];

  // Reads see the old value during a write; execute forwards around it
  assign rd_data_o = regs[rd_addr_i];
  assign rn_data_o = regs[rn_addr_i];

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      regs <= '{default: '0};
    else if (wb_i.we)
      regs[wb_i.rd] <= wb_i.data;
  end

endmodule

// File: hdl/core_execute.sv
`timescale 1ns/1ps

module core_execute
  import core_pkg::*;
(
  input  logic      core_clk,
  input  logic      rst_n_i,
  input  logic      stall_i,
  input  dec_ctrl_t dec_i,
  input  data_t     rd_data_i,
  input  data_t     rn_data_i,
  input  data_t     fwd_data_i,
  input  wb_t       wb_i,
  output exec_res_t ex_o
);

  exec_res_t ex_d;
  exec_res_t ex_q;
  data_t     rd_val;
  data_t     rn_val;
  data_t     op_b;
  data_t     alu_res;

  // Newest producer wins: memory stage, then write-back, then the register file
  function automatic data_t fwd_sel(input reg_addr_t addr, input data_t rf_data);
    if (ex_q.valid && ex_q.reg_write && (ex_q.rd == addr))
      return fwd_data_i;
    else if (wb_i.we && (wb_i.rd == addr))
      return wb_i.data;
    return rf_data;
  endfunction

  always_comb
  begin
    rd_val = fwd_sel(dec_i.rd, rd_data_i);
    rn_val = fwd_sel(dec_i.rn, rn_data_i);
  end

  assign op_b = dec_i.use_lit ? data_t'(dec_i.literal) : rn_val;

  always_comb
  begin
    case (dec_i.alu_op)
      ALU_ADD:    alu_res = rd_val + op_b;
      ALU_SUB:    alu_res = rd_val - op_b;
      ALU_AND:    alu_res = rd_val & op_b;
      ALU_OR:     alu_res = rd_val | op_b;
      ALU_XOR:    alu_res = rd_val ^ op_b;
      default:    alu_res = op_b;
    endcase
  end

  always_comb
  begin
    ex_d.valid = dec_i.valid;
    ex_d.reg_write = dec_i.reg_write;
    ex_d.mem_read = dec_i.mem_read;
    ex_d.mem_write = dec_i.mem_write;
    ex_d.rd = dec_i.rd;
    ex_d.result = alu_res;
    // STR always stores rd
    ex_d.store_data = rd_val;
  end

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ex_q <= '0;
    else if (!stall_i)
      ex_q <= ex_d;
  end

  assign ex_o = ex_q;

endmodule

// File: hdl/core_memory.sv
`timescale 1ns/1ps

module core_memory
  import core_pkg::*;
(
  input  logic      core_clk,
  input  logic      rst_n_i,
  input  exec_res_t ex_i,
  output logic      stall_o,
  output data_t     fwd_data_o,
  output wb_t       wb_o,
  output addr_t     mem_addr_o,
  output data_t     mem_data_o,
  output logic      mem_read_o,
  output logic      mem_write_o,
  output logic      mem_valid_o,
  input  data_t     mem_data_i,
  input  logic      mem_valid_i
);

  wb_t  wb_q;
  logic done_q;
  logic mem_op;

  assign mem_op = ex_i.valid && (ex_i.mem_read || ex_i.mem_write);

  // Access stays on the bus until acknowledged, then done blocks a reissue
  assign mem_valid_o = mem_op && !done_q;
  assign mem_read_o = mem_valid_o && ex_i.mem_read;
  assign mem_write_o = mem_valid_o && ex_i.mem_write;
  assign mem_addr_o = addr_t'(ex_i.result);
  assign mem_data_o = ex_i.store_data;

  // Released in the cycle after the acknowledge
  assign stall_o = mem_op && !done_q;

  // Load data lives in wb_q once the access has completed
  assign fwd_data_o = done_q ? wb_q.data : (ex_i.mem_read ? mem_data_i : ex_i.result);

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      done_q <= 1'b0;
      wb_q <= '0;
    end
    else
    begin
      wb_q.we <= 1'b0;
      done_q <= 1'b0;
      if (ex_i.valid && !mem_op)
      begin
        wb_q.we <= ex_i.reg_write;
        wb_q.rd <= ex_i.rd;
        wb_q.data <= ex_i.result;
      end
      else if (mem_valid_o && mem_valid_i)
      begin
        wb_q.we <= ex_i.reg_write;
        wb_q.rd <= ex_i.rd;
        wb_q.data <= ex_i.mem_read ? mem_data_i : ex_i.result;
        done_q <= 1'b1;
      end
    end
  end

  assign wb_o = wb_q;

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top
  import core_pkg::*;
(
  input  logic  core_clk,
  input  logic  rst_n_i,

  // Instruction bus
  output addr_t inst_addr_o,
  output logic  inst_valid_o,
  input  inst_t inst_data_i,
  input  logic  inst_valid_i,

  // Data bus
  output addr_t mem_addr_o,
  output data_t mem_data_o,
  output logic  mem_read_o,
  output logic  mem_write_o,
  output logic  mem_valid_o,
  input  data_t mem_data_i,
  input  logic  mem_valid_i
);

  inst_t     fetch_inst;
  logic      fetch_valid;
  dec_ctrl_t dec;
  data_t     rd_data;
  data_t     rn_data;
  exec_res_t ex;
  wb_t       wb;
  data_t     fwd_data;
  logic      stall;

  core_ifetch ifetch0 (
    .core_clk      (core_clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall),
    .inst_addr_o   (inst_addr_o),
    .inst_valid_o  (inst_valid_o),
    .inst_data_i   (inst_data_i),
    .inst_valid_i  (inst_valid_i),
    .fetch_inst_o  (fetch_inst),
    .fetch_valid_o (fetch_valid)
  );

  core_decode decode0 (
    .core_clk      (core_clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall),
    .fetch_inst_i  (fetch_inst),
    .fetch_valid_i (fetch_valid),
    .dec_o         (dec)
  );

  // Register read addresses come straight from the decode register
  core_regfile regfile0 (
    .core_clk  (core_clk),
    .rst_n_i   (rst_n_i),
    .rd_addr_i (dec.rd),
    .rn_addr_i (dec.rn),
    .rd_data_o (rd_data),
    .rn_data_o (rn_data),
    .wb_i      (wb)
  );

  core_execute execute0 (
    .core_clk   (core_clk),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall),
    .dec_i      (dec),
    .rd_data_i  (rd_data),
    .rn_data_i  (rn_data),
    .fwd_data_i (fwd_data),
    .wb_i       (wb),
    .ex_o       (ex)
  );

  core_memory memory0 (
    .core_clk    (core_clk),
    .rst_n_i     (rst_n_i),
    .ex_i        (ex),
    .stall_o     (stall),
    .fwd_data_o  (fwd_data),
    .wb_o        (wb),
    .mem_addr_o  (mem_addr_o),
    .mem_data_o  (mem_data_o),
    .mem_read_o  (mem_read_o),
    .mem_write_o (mem_write_o),
    .mem_valid_o (mem_valid_o),
    .mem_data_i  (mem_data_i),
    .mem_valid_i (mem_valid_i)
  );

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb
  import core_pkg::*;
();

  typedef struct packed {
    addr_t addr;
    data_t data;
  } store_t;

  logic  core_clk = 1'b0;
  logic  rst_n_i;
  addr_t inst_addr_o;
  logic  inst_valid_o;
  inst_t inst_data_i;
  logic  inst_valid_i;
  addr_t mem_addr_o;
  data_t mem_data_o;
  logic  mem_read_o;
  logic  mem_write_o;
  logic  mem_valid_o;
  data_t mem_data_i;
  logic  mem_valid_i;

  inst_t  imem [1024];
  data_t  dmem [256];
  inst_t  prog [$];
  store_t got_q [$];
  store_t exp_q [$];
  addr_t  fetch_q [$];
  int     inst_lat_max;
  int     mem_lat_max;
  int     held_cycles;
  int     test_errors;
  int     pass_count;
  int     fail_count;

  core_top dut0 (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n_i),
    .inst_addr_o  (inst_addr_o),
    .inst_valid_o (inst_valid_o),
    .inst_data_i  (inst_data_i),
    .inst_valid_i (inst_valid_i),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o),
    .mem_read_o   (mem_read_o),
    .mem_write_o  (mem_write_o),
    .mem_valid_o  (mem_valid_o),
    .mem_data_i   (mem_data_i),
    .mem_valid_i  (mem_valid_i)
  );

  always #20 core_clk = ~core_clk;

  // Every address bit shows up in the word
  function automatic data_t fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a, ~a, a ^ 8'h5a, a + 8'd1};
  endfunction

  // Anything past the loaded image reads as NOP
  function automatic inst_t fetch_word(input addr_t a);
    if (a[31:11] == '0)
      return imem[a[10:1]];
    return '0;
  endfunction

  function automatic inst_t enc_rr(input op_e op, input int rd, input int rn);
    return {op, rd[3:0], rn[3:0], 4'h0};
  endfunction

  function automatic inst_t enc_ri(input op_e op, input int rd, input int lit);
    return {op, rd[3:0], lit[7:0]};
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] time %0d ns %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] time %0d ns %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] time %0d ns %s got %b expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // Instruction bus, answers each request after 0 to inst_lat_max idle cycles
  initial
  begin
    addr_t req_addr;
    logic  busy;
    logic  take;
    int    wait_left;
    inst_valid_i = 1'b0;
    inst_data_i = '0;
    busy = 1'b0;
    wait_left = 0;
    req_addr = '0;
    forever
    begin
      @(posedge core_clk);
      #1;
      take = 1'b0;
      if (!rst_n_i)
        busy = 1'b0;
      else if (inst_valid_o)
      begin
        if (!busy)
        begin
          busy = 1'b1;
          req_addr = inst_addr_o;
          wait_left = int'($urandom % (inst_lat_max + 1));
          fetch_q.push_back(inst_addr_o);
        end
        else
          check_addr("inst_addr_o", inst_addr_o, req_addr);
        if (wait_left == 0)
        begin
          take = 1'b1;
          busy = 1'b0;
        end
        else
          wait_left--;
      end
      else if (busy)
      begin
        $display("Instruction request at %h was dropped before the answer", req_addr);
        test_errors++;
        busy = 1'b0;
      end
      #1;
      inst_valid_i = take;
      inst_data_i = take ? fetch_word(req_addr) : '0;
    end
  end

  // Data bus, 256 words indexed by the address modulo 256
  initial
  begin
    store_t rec;
    logic   busy;
    logic   ack;
    logic   req_read;
    logic   req_write;
    int     wait_left;
    data_t  rdata;
    mem_valid_i = 1'b0;
    mem_data_i = '0;
    busy = 1'b0;
    wait_left = 0;
    rec = '0;
    req_read = 1'b0;
    req_write = 1'b0;
    forever
    begin
      @(posedge core_clk);
      #1;
      ack = 1'b0;
      rdata = '0;
      if (!rst_n_i)
        busy = 1'b0;
      else if (mem_valid_o)
      begin
        if (!busy)
        begin
          busy = 1'b1;
          rec.addr = mem_addr_o;
          rec.data = mem_data_o;
          req_read = mem_read_o;
          req_write = mem_write_o;
          wait_left = int'($urandom % (mem_lat_max + 1));
          if (mem_read_o == mem_write_o)
          begin
            $display("Data access at %h has mem_read_o equal to mem_write_o", mem_addr_o);
            test_errors++;
          end
        end
        else
        begin
          // Request must not move while it waits
          held_cycles++;
          check_addr("mem_addr_o", mem_addr_o, rec.addr);
          check_data("mem_data_o", mem_data_o, rec.data);
          check_flag("mem_read_o", mem_read_o, req_read);
          check_flag("mem_write_o", mem_write_o, req_write);
        end
        if (wait_left == 0)
        begin
          ack = 1'b1;
          busy = 1'b0;
          if (mem_write_o)
          begin
            dmem[rec.addr[7:0]] = rec.data;
            got_q.push_back(rec);
          end
          else
            rdata = dmem[rec.addr[7:0]];
        end
        else
          wait_left--;
      end
      else if (busy)
      begin
        $display("Data access at %h was dropped before the answer", rec.addr);
        test_errors++;
        busy = 1'b0;
      end
      #1;
      mem_valid_i = ack;
      mem_data_i = rdata;
    end
  end

  // Sequential reference, one instruction at a time
  task automatic run_model();
    data_t     regs [16];
    data_t     mm [256];
    store_t    rec;
    inst_t     ins;
    reg_addr_t rd;
    reg_addr_t rn;
    data_t     lit;
    int        i;
    exp_q.delete();
    for (i = 0; i < 16; i++)
      regs[i] = '0;
    for (i = 0; i < 256; i++)
      mm[i] = fill_word(i);
    for (i = 0; i < prog.size(); i++)
    begin
      ins = prog[i];
      rd = ins[11:8];
      rn = ins[7:4];
      lit = data_t'(ins[7:0]);
      case (op_e'(ins[15:12]))
        OP_MOVI: regs[rd] = lit;
        OP_ADD:  regs[rd] = regs[rd] + regs[rn];
        OP_SUB:  regs[rd] = regs[rd] - regs[rn];
        OP_AND:  regs[rd] = regs[rd] & regs[rn];
        OP_OR:   regs[rd] = regs[rd] | regs[rn];
        OP_XOR:  regs[rd] = regs[rd] ^ regs[rn];
        OP_ADDI: regs[rd] = regs[rd] + lit;
        OP_LDR:  regs[rd] = mm[regs[rn][7:0]];
        OP_STR:
        begin
          rec.addr = addr_t'(regs[rn]);
          rec.data = regs[rd];
          exp_q.push_back(rec);
          mm[regs[rn][7:0]] = regs[rd];
        end
        default: ;
      endcase
    end
  endtask

  // Loads the program and memories while the core is held in reset
  task automatic apply_reset();
    int i;
    @(posedge core_clk);
    #2;
    rst_n_i = 1'b0;
    for (i = 0; i < 1024; i++)
      imem[i] = '0;
    for (i = 0; i < prog.size(); i++)
      imem[i] = prog[i];
    for (i = 0; i < 256; i++)
      dmem[i] = fill_word(i);
    repeat (5) @(posedge core_clk);
    got_q.delete();
    fetch_q.delete();
    held_cycles = 0;
    #2;
    rst_n_i = 1'b1;
  endtask

  task automatic wait_stores(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (got_q.size() < n && cycles < limit)
    begin
      @(negedge core_clk);
      cycles++;
    end
    if (got_q.size() < n)
    begin
      $display("Timeout after %0d cycles with %0d of %0d stores seen", limit, got_q.size(), n);
      test_errors++;
    end
  endtask

  task automatic compare_stores();
    int i;
    if (got_q.size() != exp_q.size())
    begin
      $display("Store count is %0d but the model has %0d", got_q.size(), exp_q.size());
      test_errors++;
    end
    for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
    begin
      check_addr($sformatf("store %0d mem_addr_o", i), got_q[i].addr, exp_q[i].addr);
      check_data($sformatf("store %0d mem_data_o", i), got_q[i].data, exp_q[i].data);
    end
  endtask

  task automatic run_program(input int limit);
    run_model();
    apply_reset();
    wait_stores(exp_q.size(), limit);
    compare_stores();
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
    begin
      pass_count++;
      $display("%s: passed", name);
    end
    else
    begin
      fail_count++;
      $display("%s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial
  begin
    int i;
    int op;
    int body;
    int cycles;
    rst_n_i = 1'b0;
    inst_lat_max = 5;
    mem_lat_max = 5;
    held_cycles = 0;
    test_errors = 0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(32'h7cf1));

    // Reset state, then the fetch address walk over NOPs
    prog.delete();
    run_model();
    apply_reset();
    @(negedge core_clk);
    check_flag("inst_valid_o", inst_valid_o, 1'b1);
    check_addr("inst_addr_o", inst_addr_o, `RESET_PC);
    cycles = 0;
    while (fetch_q.size() < 8 && cycles < 200)
    begin
      check_flag("mem_valid_o", mem_valid_o, 1'b0);
      @(negedge core_clk);
      cycles++;
    end
    if (fetch_q.size() < 8)
    begin
      $display("Timeout with only %0d fetches seen after reset", fetch_q.size());
      test_errors++;
    end
    else
    begin
      check_addr("first inst_addr_o", fetch_q[0], `RESET_PC);
      for (i = 1; i < fetch_q.size(); i++)
        check_addr($sformatf("fetch %0d inst_addr_o", i), fetch_q[i], fetch_q[i-1] + addr_t'(2));
    end
    end_test("reset and fetch order");

    // Back to back chain so that both forwarding paths are taken
    inst_lat_max = 0;
    mem_lat_max = 0;
    prog.delete();
    prog.push_back(enc_ri(OP_MOVI, 1, 8'h15));
    prog.push_back(enc_ri(OP_MOVI, 2, 8'h0c));
    prog.push_back(enc_rr(OP_ADD, 2, 1));
    prog.push_back(enc_rr(OP_XOR, 1, 2));
    prog.push_back(enc_rr(OP_SUB, 2, 1));
    prog.push_back(enc_rr(OP_OR, 3, 2));
    prog.push_back(enc_rr(OP_AND, 3, 1));
    prog.push_back(enc_ri(OP_ADDI, 3, 8'h7f));
    prog.push_back(enc_ri(OP_MOVI, 4, 8'h40));
    prog.push_back(enc_rr(OP_STR, 1, 4));
    prog.push_back(enc_ri(OP_ADDI, 4, 8'h04));
    prog.push_back(enc_rr(OP_STR, 2, 4));
    prog.push_back(enc_ri(OP_ADDI, 4, 8'h04));
    prog.push_back(enc_rr(OP_STR, 3, 4));
    run_program(500);
    end_test("forwarding chain");

    // Load result used by the very next instruction
    mem_lat_max = 2;
    prog.delete();
    prog.push_back(enc_ri(OP_MOVI, 5, 8'h10));
    prog.push_back(enc_ri(OP_MOVI, 6, 8'h33));
    prog.push_back(enc_rr(OP_LDR, 7, 5));
    prog.push_back(enc_rr(OP_ADD, 7, 6));
    prog.push_back(enc_rr(OP_STR, 7, 5));
    prog.push_back(enc_rr(OP_LDR, 8, 5));
    prog.push_back(enc_ri(OP_ADDI, 8, 8'h01));
    prog.push_back(enc_rr(OP_STR, 8, 6));
    run_program(500);
    end_test("load then dependent use");

    // Slow buses on both sides
    inst_lat_max = 5;
    mem_lat_max = 5;
    prog.delete();
    prog.push_back(enc_ri(OP_MOVI, 1, 8'h08));
    prog.push_back(enc_ri(OP_MOVI, 2, 8'h21));
    prog.push_back(enc_rr(OP_STR, 2, 1));
    prog.push_back(enc_rr(OP_LDR, 3, 1));
    prog.push_back(enc_ri(OP_ADDI, 3, 8'h05));
    prog.push_back(enc_rr(OP_STR, 3, 3));
    prog.push_back(enc_rr(OP_LDR, 4, 2));
    prog.push_back(enc_rr(OP_XOR, 4, 3));
    prog.push_back(enc_rr(OP_STR, 4, 1));
    run_program(1000);
    if (held_cycles == 0)
    begin
      $display("No data access was held for more than one cycle");
      test_errors++;
    end
    end_test("bus latency and hold");

    // Opcodes 10 and 11 are undefined and act as NOP
    prog.delete();
    for (i = 0; i < 184; i++)
    begin
      op = int'($urandom % 12);
      body = int'($urandom);
      prog.push_back({op[3:0], body[11:0]});
    end
    for (i = 0; i < 16; i++)
      prog.push_back(enc_rr(OP_STR, i, (i + 1) % 16));
    run_program(20000);
    end_test("random program");

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hdl/core_pkg.sv
hdl/core_ifetch.sv
hdl/core_decode.sv
hdl/core_regfile.sv
hdl/core_execute.sv
hdl/core_memory.sv
hdl/core_top.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module core_tb -Mdir obj_dir -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vcore_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
